// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = DatapathTb
FILELIST = list.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /^>>> PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== list.f ====
verilog/MipsPkg.sv
verilog/Fetch.sv
verilog/Decode.sv
verilog/Execute.sv
verilog/Result.sv
verilog/Datapath.sv
verification/TbMemories.sv
verification/DatapathTb.sv

// ==== verification/DatapathTb.sv ====
`timescale 1ns/1ps

module DatapathTb;
    import MipsPkg::*;

    localparam Word ResetVector = 32'h0000_0000;
    localparam int ProgramLength = 120;
    localparam int HaltIndex = ProgramLength + 7;
    localparam Word HaltAddr = ResetVector + 32'(HaltIndex * 4);
    localparam int RomWords = 256;
    localparam int RamWords = 64;
    localparam int HaltTimeout = 2000;
    localparam int DrainCycles = 4;

    logic clk;
    logic reset;
    Word IAddr;
    Word IRead;
    logic DEn;
    Word DAddr;
    Word DRead;
    logic DWriteEN;
    Word DWrite;

    Word programWords [0:HaltIndex];
    Word modelRegs [0:31];
    Word modelRam [0:RamWords-1];
    Word expectAddr [$];
    Word expectData [$];
    Word rngState;
    int storeCount = 0;
    int accessCount = 0;
    int expectAccesses = 0;
    int valueErrors = 0;
    int countErrors = 0;
    int timeoutErrors = 0;

    Datapath #(
        .ResetVector(ResetVector)
    ) u_dut (
        .clk(clk),
        .reset(reset),
        .IAddr(IAddr),
        .IRead(IRead),
        .DEn(DEn),
        .DAddr(DAddr),
        .DRead(DRead),
        .DWriteEN(DWriteEN),
        .DWrite(DWrite)
    );

    TbMemories #(
        .RomWords(RomWords),
        .RamWords(RamWords)
    ) mems (
        .clk(clk),
        .IAddr(IAddr),
        .IRead(IRead),
        .DEn(DEn),
        .DAddr(DAddr),
        .DRead(DRead),
        .DWriteEN(DWriteEN),
        .DWrite(DWrite)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic Word nextRandom();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    function automatic int randomBelow(int limit);
        Word r;
        r = nextRandom();
        return int'(r[30:16]) % limit;
    endfunction

    function automatic RegIndex randomReg();
        return RegIndex'(1 + randomBelow(7));
    endfunction

    function automatic Word rTypeWord(logic [5:0] funct, RegIndex rs, RegIndex rt, RegIndex rd);
        return {OpcodeSpecial, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic Word immWord(logic [5:0] opcode, RegIndex rs, RegIndex rt,
                                    logic [15:0] imm);
        return {opcode, rs, rt, imm};
    endfunction

    function automatic Word ramFill(int index);
        Word a;
        a = 32'(index) << 2;
        return {a[15:0] ^ 16'hc3a5, ~a[15:0]};
    endfunction

    task automatic buildProgram();
        int kind;
        int skip;
        RegIndex rs;
        RegIndex rt;
        RegIndex rd;
        Word r;
        logic [15:0] offset;
        // Give r1..r7 known values first
        for (int i = 0; i < 7; i++) begin
            r = nextRandom();
            programWords[7'(i)] = immWord(OpcodeAddiu, 5'd0, RegIndex'(i + 1), r[15:0]);
        end
        for (int i = 7; i < ProgramLength; i++) begin
            r = nextRandom();
            rs = randomReg();
            rt = randomReg();
            rd = randomReg();
            offset = 16'(randomBelow(32) * 4);
            kind = randomBelow(16);
            // Forward targets never pass the epilogue start
            skip = 1 + randomBelow(4);
            if (i + 1 + skip > ProgramLength) begin
                skip = ProgramLength - 1 - i;
            end
            if (kind >= 13 && skip < 1) begin
                kind = 6;
            end
            case (kind)
                0: programWords[7'(i)] = rTypeWord(FunctAddu, rs, rt, rd);
                1: programWords[7'(i)] = rTypeWord(FunctSubu, rs, rt, rd);
                2: programWords[7'(i)] = rTypeWord(FunctAnd, rs, rt, rd);
                3: programWords[7'(i)] = rTypeWord(FunctOr, rs, rt, rd);
                4, 5: programWords[7'(i)] = rTypeWord(FunctSlt, rs, rt, rd);
                6: programWords[7'(i)] = immWord(OpcodeAddiu, rs, rt, r[15:0]);
                7: programWords[7'(i)] = immWord(OpcodeOri, rs, rt, r[15:0]);
                8: programWords[7'(i)] = immWord(OpcodeLui, 5'd0, rt, r[15:0]);
                9, 10: programWords[7'(i)] = immWord(OpcodeLw, 5'd0, rt, offset);
                11, 12: programWords[7'(i)] = immWord(OpcodeSw, 5'd0, rt, offset);
                13: programWords[7'(i)] = immWord(OpcodeBeq, rs, rt, 16'(skip));
                14: programWords[7'(i)] = immWord(OpcodeBne, rs, rt, 16'(skip));
                default: begin
                    r = ResetVector + 32'((i + 1 + skip) * 4);
                    programWords[7'(i)] = {OpcodeJ, r[27:2]};
                end
            endcase
        end
        for (int j = 0; j < 7; j++) begin
            programWords[7'(ProgramLength + j)] =
                immWord(OpcodeSw, 5'd0, RegIndex'(j + 1), 16'((32 + j) * 4));
        end
        programWords[7'(HaltIndex)] = {OpcodeJ, HaltAddr[27:2]};
    endtask

    task automatic loadMemories();
        Word addr;
        // Unused ROM words carry an unsupported opcode
        for (int a = 0; a < RomWords; a++) begin
            mems.rom[8'(a)] = {6'h3f, 26'(a * 4)};
        end
        for (int i = 0; i <= HaltIndex; i++) begin
            addr = ResetVector + 32'(i * 4);
            mems.rom[addr[9:2]] = programWords[7'(i)];
        end
        for (int a = 0; a < RamWords; a++) begin
            mems.ram[6'(a)] = ramFill(a);
            modelRam[6'(a)] = ramFill(a);
        end
    endtask

    // One instruction per step, no pipeline, no delay slot
    task automatic runModel();
        Word pc;
        Word instr;
        Word a;
        Word b;
        Word sext;
        Word addr;
        Word result;
        RegIndex dest;
        logic writes;
        int steps;
        for (int r = 0; r < 32; r++) begin
            modelRegs[5'(r)] = '0;
        end
        pc = ResetVector;
        steps = 0;
        while (pc != HaltAddr && steps < 1000) begin
            instr = programWords[7'((pc - ResetVector) >> 2)];
            a = modelRegs[instr[25:21]];
            b = modelRegs[instr[20:16]];
            sext = {{16{instr[15]}}, instr[15:0]};
            addr = a + sext;
            dest = instr[20:16];
            writes = 1'b1;
            result = '0;
            pc = pc + 32'd4;
            case (instr[31:26])
                OpcodeSpecial: begin
                    dest = instr[15:11];
                    case (instr[5:0])
                        FunctAddu: result = a + b;
                        FunctSubu: result = a - b;
                        FunctAnd: result = a & b;
                        FunctOr: result = a | b;
                        FunctSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: writes = 1'b0;
                    endcase
                end
                OpcodeAddiu: result = addr;
                OpcodeOri: result = a | {16'h0000, instr[15:0]};
                OpcodeLui: result = {instr[15:0], 16'h0000};
                OpcodeLw: begin
                    result = modelRam[addr[7:2]];
                    expectAccesses++;
                end
                OpcodeSw: begin
                    writes = 1'b0;
                    modelRam[addr[7:2]] = b;
                    expectAddr.push_back(addr);
                    expectData.push_back(b);
                    expectAccesses++;
                end
                OpcodeBeq: begin
                    writes = 1'b0;
                    if (a == b) begin
                        pc = pc + (sext << 2);
                    end
                end
                OpcodeBne: begin
                    writes = 1'b0;
                    if (a != b) begin
                        pc = pc + (sext << 2);
                    end
                end
                OpcodeJ: begin
                    writes = 1'b0;
                    pc = {pc[31:28], instr[25:0], 2'b00};
                end
                default: writes = 1'b0;
            endcase
            if (writes && dest != 5'd0) begin
                modelRegs[dest] = result;
            end
            steps++;
        end
    endtask

    // Store trace, compared in order
    always @(posedge clk) begin
        if (!reset && DEn) begin
            accessCount++;
        end
        if (!reset && DWriteEN) begin
            if (storeCount >= expectAddr.size()) begin
                $display("ERR %0t: unexpected store of %h to %h", $time, DWrite, DAddr);
                valueErrors++;
            end else if (DAddr !== expectAddr[storeCount]
                         || DWrite !== expectData[storeCount]) begin
                $display("ERR %0t: store %0d wrote %h to %h, expected %h to %h", $time,
                         storeCount, DWrite, DAddr, expectData[storeCount],
                         expectAddr[storeCount]);
                valueErrors++;
            end
            storeCount++;
        end
    end

    initial begin
        int cycles;
        rngState = 32'h8b40_7ce6;
        reset = 1'b1;
        buildProgram();
        loadMemories();
        runModel();
        for (int c = 0; c < 3; c++) begin
            @(posedge clk);
        end
        reset <= 1'b0;
        @(posedge clk);
        if (IAddr !== ResetVector) begin
            $display("ERR %0t: IAddr %h after reset, expected %h", $time, IAddr, ResetVector);
            valueErrors++;
        end
        cycles = 0;
        while (IAddr !== HaltAddr && cycles < HaltTimeout) begin
            @(posedge clk);
            cycles++;
        end
        if (IAddr !== HaltAddr) begin
            $display("Timeout: the halt address was not reached within %0d cycles", HaltTimeout);
            timeoutErrors++;
        end else begin
            // Last epilogue store leaves the result stage within a few cycles
            for (int c = 0; c < DrainCycles; c++) begin
                @(posedge clk);
            end
        end
        if (storeCount != expectAddr.size()) begin
            $display("ERR %0t: %0d stores seen, expected %0d", $time, storeCount,
                     expectAddr.size());
            countErrors++;
        end
        if (accessCount != expectAccesses) begin
            $display("ERR %0t: %0d data memory accesses seen, expected %0d", $time,
                     accessCount, expectAccesses);
            countErrors++;
        end
        $display("Errors: %0d value, %0d count, %0d timeout", valueErrors, countErrors,
                 timeoutErrors);
        if (valueErrors + countErrors + timeoutErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== verification/TbMemories.sv ====
`timescale 1ns/1ps

module TbMemories #(
    parameter int RomWords = 256,
    parameter int RamWords = 64
) (
    input logic clk,
    input MipsPkg::Word IAddr,
    output MipsPkg::Word IRead,
    input logic DEn,
    input MipsPkg::Word DAddr,
    output MipsPkg::Word DRead,
    input logic DWriteEN,
    input MipsPkg::Word DWrite
);
    import MipsPkg::*;

    localparam int RomBits = $clog2(RomWords);
    localparam int RamBits = $clog2(RamWords);

    // Both arrays are preloaded by the testbench at time zero
    Word rom [0:RomWords-1];
    Word ram [0:RamWords-1];

    assign IRead = rom[IAddr[RomBits+1:2]];
    assign DRead = DEn ? ram[DAddr[RamBits+1:2]] : '0;

    always @(posedge clk) begin
        if (DWriteEN) begin
            ram[DAddr[RamBits+1:2]] <= DWrite;
        end
    end

endmodule

// ==== verilog/Datapath.sv ====
`timescale 1ns/1ps

module Datapath #(
    parameter MipsPkg::Word ResetVector = 32'h0000_0000
) (
    input logic clk,
    input logic reset,

    output MipsPkg::Word IAddr,
    input MipsPkg::Word IRead,

    output logic DEn,
    output MipsPkg::Word DAddr,
    input MipsPkg::Word DRead,
    output logic DWriteEN,
    output MipsPkg::Word DWrite
);
    import MipsPkg::*;

    Redirect redirect;
    FetchToDecode fetched;
    DecodeToExecute decoded;
    ExecuteToResult executed;
    WriteBack writeBack;

    Fetch #(
        .ResetVector(ResetVector)
    ) fetch (
        .clk(clk),
        .reset(reset),
        .redirect(redirect),
        .IAddr(IAddr),
        .IRead(IRead),
        .fetched(fetched)
    );

    // Taken branch in execute squashes the instruction in decode
    Decode decode (
        .clk(clk),
        .reset(reset),
        .flush(redirect.taken),
        .fetched(fetched),
        .writeBack(writeBack),
        .decoded(decoded)
    );

    Execute execute (
        .clk(clk),
        .reset(reset),
        .decoded(decoded),
        .writeBack(writeBack),
        .redirect(redirect),
        .executed(executed)
    );

    Result result (
        .clk(clk),
        .executed(executed),
        .DEn(DEn),
        .DAddr(DAddr),
        .DRead(DRead),
        .DWriteEN(DWriteEN),
        .DWrite(DWrite),
        .writeBack(writeBack)
    );

endmodule

// ==== verilog/Decode.sv ====
`timescale 1ns/1ps

module Decode (
    input logic clk,
    input logic reset,
    input logic flush,
    input MipsPkg::FetchToDecode fetched,
    input MipsPkg::WriteBack writeBack,
    output MipsPkg::DecodeToExecute decoded
);
    import MipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    RegIndex rsField;
    RegIndex rtField;
    RegIndex rdField;
    logic [15:0] imm16;
    logic [25:0] jumpIndex;

    MipsOp op;
    Word regFile [0:31];
    DecodeToExecute nextDecoded;

    assign opcode = fetched.instr[31:26];
    assign rsField = fetched.instr[25:21];
    assign rtField = fetched.instr[20:16];
    assign rdField = fetched.instr[15:11];
    assign imm16 = fetched.instr[15:0];
    assign funct = fetched.instr[5:0];
    assign jumpIndex = fetched.instr[25:0];

    always_comb begin
        op = OpNop;
        case (opcode)
            OpcodeSpecial: begin
                case (funct)
                    FunctAddu: op = OpAddu;
                    FunctSubu: op = OpSubu;
                    FunctAnd: op = OpAnd;
                    FunctOr: op = OpOr;
                    FunctSlt: op = OpSlt;
                    default: op = OpNop;
                endcase
            end
            OpcodeAddiu: op = OpAddiu;
            OpcodeOri: op = OpOri;
            OpcodeLui: op = OpLui;
            OpcodeLw: op = OpLw;
            OpcodeSw: op = OpSw;
            OpcodeBeq: op = OpBeq;
            OpcodeBne: op = OpBne;
            OpcodeJ: op = OpJ;
            default: op = OpNop;
        endcase
    end

    // Write in the same cycle is visible to the read
    function automatic Word readReg(RegIndex index);
        Word value;
        if (index == '0) begin
            value = '0;
        end else if (writeBack.writeEn && writeBack.dest == index) begin
            value = writeBack.data;
        end else begin
            value = regFile[index];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (writeBack.writeEn && writeBack.dest != '0) begin
            regFile[writeBack.dest] <= writeBack.data;
        end
    end

    always_comb begin
        nextDecoded.valid = fetched.valid && !flush;
        nextDecoded.op = op;
        nextDecoded.rs = rsField;
        nextDecoded.rt = rtField;
        nextDecoded.regRd1 = readReg(rsField);
        nextDecoded.regRd2 = readReg(rtField);
        nextDecoded.pcPlus4 = fetched.pcPlus4;
        nextDecoded.jumpTarget = {fetched.pc[31:28], jumpIndex, 2'b00};

        // R-type writes rd, immediates and loads write rt
        case (op)
            OpAddu, OpSubu, OpAnd, OpOr, OpSlt: begin
                nextDecoded.dest = rdField;
                nextDecoded.writeEn = 1'b1;
            end
            OpAddiu, OpOri, OpLui, OpLw: begin
                nextDecoded.dest = rtField;
                nextDecoded.writeEn = 1'b1;
            end
            default: begin
                nextDecoded.dest = rtField;
                nextDecoded.writeEn = 1'b0;
            end
        endcase

        case (op)
            OpOri: nextDecoded.imm32 = {16'h0000, imm16};
            OpLui: nextDecoded.imm32 = {imm16, 16'h0000};
            default: nextDecoded.imm32 = {{16{imm16[15]}}, imm16};
        endcase
    end

    always_ff @(posedge clk) begin
        decoded <= nextDecoded;
        if (reset) begin
            decoded.valid <= 1'b0;
        end
    end

    // Register 0 stays zero for readers even while a write targets it
    ZeroRegisterHeld: assert property (
        @(posedge clk) disable iff (reset)
        (writeBack.writeEn && writeBack.dest == '0)
            |-> (rsField != '0 || nextDecoded.regRd1 == '0)
                && (rtField != '0 || nextDecoded.regRd2 == '0)
    );

endmodule

// ==== verilog/Execute.sv ====
`timescale 1ns/1ps

module Execute (
    input logic clk,
    input logic reset,
    input MipsPkg::DecodeToExecute decoded,
    input MipsPkg::WriteBack writeBack,
    output MipsPkg::Redirect redirect,
    output MipsPkg::ExecuteToResult executed
);
    import MipsPkg::*;

    Word srcA;
    Word srcB;
    Word aluOut;
    Word branchTarget;
    logic operandsEqual;
    logic takeBranch;
    ExecuteToResult nextExecuted;

    // Result stage holds the only in-flight value not yet in the register file
    function automatic Word forwardOperand(RegIndex index, Word regValue);
        Word value;
        value = regValue;
        if (writeBack.writeEn && writeBack.dest != '0 && writeBack.dest == index) begin
            value = writeBack.data;
        end
        return value;
    endfunction

    assign srcA = forwardOperand(decoded.rs, decoded.regRd1);
    assign srcB = forwardOperand(decoded.rt, decoded.regRd2);

    always_comb begin
        case (decoded.op)
            OpAddu: aluOut = srcA + srcB;
            OpSubu: aluOut = srcA - srcB;
            OpAnd: aluOut = srcA & srcB;
            OpOr: aluOut = srcA | srcB;
            OpSlt: aluOut = {31'd0, $signed(srcA) < $signed(srcB)};
            OpAddiu, OpLw, OpSw: aluOut = srcA + decoded.imm32;
            OpOri: aluOut = srcA | decoded.imm32;
            OpLui: aluOut = decoded.imm32;
            default: aluOut = '0;
        endcase
    end

    assign operandsEqual = srcA == srcB;
    assign branchTarget = decoded.pcPlus4 + {decoded.imm32[29:0], 2'b00};

    always_comb begin
        case (decoded.op)
            OpBeq: takeBranch = operandsEqual;
            OpBne: takeBranch = !operandsEqual;
            OpJ: takeBranch = 1'b1;
            default: takeBranch = 1'b0;
        endcase
    end

    always_comb begin
        redirect.taken = decoded.valid && takeBranch;
        if (decoded.op == OpJ) begin
            redirect.target = decoded.jumpTarget;
        end else begin
            redirect.target = branchTarget;
        end
    end

    // A redirecting record does no work later on
    always_comb begin
        nextExecuted.valid = decoded.valid && !redirect.taken;
        nextExecuted.op = decoded.op;
        nextExecuted.writeEn = decoded.writeEn;
        nextExecuted.dest = decoded.dest;
        nextExecuted.aluOut = aluOut;
        nextExecuted.storeData = srcB;
    end

    always_ff @(posedge clk) begin
        executed <= nextExecuted;
        if (reset) begin
            executed.valid <= 1'b0;
        end
    end

    // Fetch only ever holds aligned addresses
    RedirectAligned: assert property (
        @(posedge clk) disable iff (reset)
        redirect.taken |-> redirect.target[1:0] == 2'b00
    );

endmodule

// ==== verilog/Fetch.sv ====
`timescale 1ns/1ps

module Fetch #(
    parameter MipsPkg::Word ResetVector = 32'h0000_0000
) (
    input logic clk,
    input logic reset,
    input MipsPkg::Redirect redirect,
    output MipsPkg::Word IAddr,
    input MipsPkg::Word IRead,
    output MipsPkg::FetchToDecode fetched
);
    import MipsPkg::*;

    Word pc;
    Word pcPlus4;
    FetchToDecode nextFetched;

    assign pcPlus4 = pc + 32'd4;
    assign IAddr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= ResetVector;
        end else if (redirect.taken) begin
            pc <= redirect.target;
        end else begin
            pc <= pcPlus4;
        end
    end

    // Word fetched under a redirect is a wrong-path instruction
    always_comb begin
        nextFetched.valid = !redirect.taken;
        nextFetched.pc = pc;
        nextFetched.pcPlus4 = pcPlus4;
        nextFetched.instr = IRead;
    end

    always_ff @(posedge clk) begin
        fetched <= nextFetched;
        if (reset) begin
            fetched.valid <= 1'b0;
        end
    end

endmodule

// ==== verilog/MipsPkg.sv ====
package MipsPkg;

    typedef logic [31:0] Word;
    typedef logic [4:0] RegIndex;

    // Decoded operations, unknown encodings map to OpNop
    typedef enum logic [3:0] {
        OpNop,
        OpAddu,
        OpSubu,
        OpAnd,
        OpOr,
        OpSlt,
        OpAddiu,
        OpOri,
        OpLui,
        OpLw,
        OpSw,
        OpBeq,
        OpBne,
        OpJ
    } MipsOp;

    // Primary opcode field
    localparam logic [5:0] OpcodeSpecial = 6'h00;
    localparam logic [5:0] OpcodeJ = 6'h02;
    localparam logic [5:0] OpcodeBeq = 6'h04;
    localparam logic [5:0] OpcodeBne = 6'h05;
    localparam logic [5:0] OpcodeAddiu = 6'h09;
    localparam logic [5:0] OpcodeOri = 6'h0d;
    localparam logic [5:0] OpcodeLui = 6'h0f;
    localparam logic [5:0] OpcodeLw = 6'h23;
    localparam logic [5:0] OpcodeSw = 6'h2b;

    // Function field of SPECIAL
    localparam logic [5:0] FunctAddu = 6'h21;
    localparam logic [5:0] FunctSubu = 6'h23;
    localparam logic [5:0] FunctAnd = 6'h24;
    localparam logic [5:0] FunctOr = 6'h25;
    localparam logic [5:0] FunctSlt = 6'h2a;

    typedef struct packed {
        logic valid;
        Word pc;
        Word pcPlus4;
        Word instr;
    } FetchToDecode;

    typedef struct packed {
        logic valid;
        MipsOp op;
        RegIndex rs;
        RegIndex rt;
        RegIndex dest;
        Word regRd1;
        Word regRd2;
        Word imm32;
        Word pcPlus4;
        Word jumpTarget;
        logic writeEn;
    } DecodeToExecute;

    typedef struct packed {
        logic valid;
        MipsOp op;
        logic writeEn;
        RegIndex dest;
        Word aluOut;
        Word storeData;
    } ExecuteToResult;

    typedef struct packed {
        logic writeEn;
        RegIndex dest;
        Word data;
    } WriteBack;

    typedef struct packed {
        logic taken;
        Word target;
    } Redirect;

endpackage

// ==== verilog/Result.sv ====
`timescale 1ns/1ps

module Result (
    input logic clk,
    input MipsPkg::ExecuteToResult executed,
    output logic DEn,
    output MipsPkg::Word DAddr,
    input MipsPkg::Word DRead,
    output logic DWriteEN,
    output MipsPkg::Word DWrite,
    output MipsPkg::WriteBack writeBack
);
    import MipsPkg::*;

    logic isLoad;
    logic isStore;

    assign isLoad = executed.op == OpLw;
    assign isStore = executed.op == OpSw;

    // Data memory request
    assign DEn = executed.valid && (isLoad || isStore);
    assign DWriteEN = executed.valid && isStore;
    assign DAddr = executed.aluOut;
    assign DWrite = executed.storeData;

    // Memory answers in the same cycle, so loads write back directly
    always_comb begin
        writeBack.writeEn = executed.valid && executed.writeEn;
        writeBack.dest = executed.dest;
        if (isLoad) begin
            writeBack.data = DRead;
        end else begin
            writeBack.data = executed.aluOut;
        end
    end

    // Word accesses only
    AccessAligned: assert property (
        @(posedge clk) DEn |-> DAddr[1:0] == 2'b00
    );

endmodule
